// ==== bench/csr_cases.txt ====
# name kind addr data lines pc instr exp_rdata exp_irq exp_trap exp_target (hex)
# wr to mscratch uses random data, cyc waits data cycles and expects the delta
rst_mie      rd  304 0        00 0        0        00000001 0 0 0
rst_mtvec    rd  305 0        00 0        0        00000000 0 0 0
rst_mscratch rd  340 0        00 0        0        00000000 0 0 0
rst_mepc     rd  341 0        00 0        0        00000000 0 0 0
rst_mcause   rd  342 0        00 0        0        00000000 0 0 0
rst_mtval    rd  343 0        00 0        0        00000000 0 0 0
rst_mcycleh  rd  b80 0        00 0        0        00000000 0 0 0
bad_addr     rd  7c0 0        00 0        0        00000000 0 0 0
wr_mtvec     wr  305 00001000 00 0        0        00001000 0 0 0
wr_mscratch  wr  340 0        00 0        0        00000000 0 0 0
wr_mepc      wr  341 deadbeef 00 0        0        00000000 0 0 0
wr_mcause    wr  342 ffffffff 00 0        0        00000000 0 0 0
wr_mtval     wr  343 12345678 00 0        0        00000000 0 0 0
wr_mcycleh   wr  b80 12345678 00 0        0        00000000 0 0 0
wr_bad       wr  7c0 00000001 00 0        0        00000000 0 0 0
mask_off     irq 342 0        02 00000100 00000013 00000000 0 0 0
trap_direct  irq 342 0        01 00000200 00100073 80000001 1 1 00001000
rd_mepc      rd  341 0        00 00000200 0        00000200 1 0 0
rd_mtval     rd  343 0        00 00000200 0        00100073 1 0 0
wr_mie       wr  304 0000003f 00 0        0        0000003f 1 0 0
no_reentry   irq 341 0        05 00000300 00000000 00000200 1 0 0
drop_all     irq 342 0        00 00000300 00000000 00000000 0 0 0
wr_mtvec_vec wr  305 00002001 00 0        0        00002001 0 0 0
trap_vec     irq 342 0        0c 00000400 00000073 8000000c 1 1 00002008
rd_mepc2     rd  341 0        00 00000400 0        00000400 1 0 0
rd_mtval2    rd  343 0        00 00000400 0        00000073 1 0 0
drop_again   irq 342 0        00 00000400 00000000 00000000 0 0 0
cyc_delta    cyc b00 0000000a 00 0        0        0000000a 0 0 0
rd_mcycleh   rd  b80 0        00 0        0        00000000 0 0 0

// ==== csr_subsys_top.f ====
logic/csr_pkg.sv
logic/trap_pkg.sv
logic/event_source.sv
logic/csr_file.sv
logic/trap_ctrl.sv
logic/csr_subsys_top.sv
bench/csr_checker.sv
bench/csr_subsys_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        := csr_subsys_tb
FILELIST   := csr_subsys_top.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q '>>> PASS' $(LOG) || (echo "simulation did not finish"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/csr_subsys_tb.sv ====
module csr_subsys_tb
    import csr_pkg::*;
    import trap_pkg::*;
();

    localparam int MAX_CASES = 64;

    logic                 clk;
    logic                 rst_n;
    csr_req_t             csr;
    logic [31:0]          pc;
    logic [31:0]          instr;
    logic [IRQ_LINES-1:0] mei;
    logic [31:0]          rdata;
    logic                 irq;
    trap_req_t            trap;

    logic                 chk;
    logic [1:0]           mode;
    logic [127:0]         name;
    logic [31:0]          exp_rdata;
    logic                 exp_irq;
    logic                 exp_trap;
    logic [31:0]          exp_target;
    logic [31:0]          exp_epc;
    int                   pass_cnt;
    int                   fail_cnt;

    logic [127:0]          c_name   [MAX_CASES];
    string                 c_kind   [MAX_CASES];
    logic [CSR_ADDR_W-1:0] c_addr   [MAX_CASES];
    logic [31:0]           c_data   [MAX_CASES];
    logic [IRQ_LINES-1:0]  c_lines  [MAX_CASES];
    logic [31:0]           c_pc     [MAX_CASES];
    logic [31:0]           c_instr  [MAX_CASES];
    logic [31:0]           c_exp    [MAX_CASES];
    logic                  c_irq    [MAX_CASES];
    logic                  c_trap   [MAX_CASES];
    logic [31:0]           c_target [MAX_CASES];
    int                    n_cases = 0;
    logic [31:0]           seed;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    csr_subsys_top i_csr_subsys_top (
        .i_CLK       (clk),
        .i_rst_n     (rst_n),
        .i_csr       (csr),
        .i_pc        (pc),
        .i_instr     (instr),
        .i_mei       (mei),
        .o_csr_rdata (rdata),
        .o_irq       (irq),
        .o_trap      (trap)
    );

    csr_checker u_checker (
        .i_CLK        (clk),
        .i_rst_n      (rst_n),
        .i_rdata      (rdata),
        .i_irq        (irq),
        .i_trap       (trap),
        .i_chk        (chk),
        .i_mode       (mode),
        .i_name       (name),
        .i_exp_rdata  (exp_rdata),
        .i_exp_irq    (exp_irq),
        .i_exp_trap   (exp_trap),
        .i_exp_target (exp_target),
        .i_exp_epc    (exp_epc),
        .o_pass_cnt   (pass_cnt),
        .o_fail_cnt   (fail_cnt)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic load_cases;
        int    fd;
        int    cnt;
        string line;
        fd = $fopen("bench/csr_cases.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && n_cases < MAX_CASES) begin
                cnt = $fgets(line, fd);
                if (cnt > 4 && line[0] != "#") begin
                    cnt = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h",
                                  c_name[n_cases], c_kind[n_cases], c_addr[n_cases],
                                  c_data[n_cases], c_lines[n_cases], c_pc[n_cases],
                                  c_instr[n_cases], c_exp[n_cases], c_irq[n_cases],
                                  c_trap[n_cases], c_target[n_cases]);
                    if (cnt == 11) n_cases = n_cases + 1;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic set_check(input int i, input logic [31:0] exp, input logic [1:0] m);
        name       = c_name[i];
        exp_rdata  = exp;
        exp_irq    = c_irq[i];
        exp_trap   = c_trap[i];
        exp_target = c_target[i];
        exp_epc    = c_pc[i];
        mode       = m;
        chk        = 1'b1;
    endtask

    task automatic run_case(input int i);
        logic [31:0] wdata;
        logic [31:0] exp;
        wdata = c_data[i];
        exp   = c_exp[i];
        if (c_kind[i] == "wr" && c_addr[i] == CSR_MSCRATCH) begin
            seed  = xorshift(seed);     // random scratch data
            wdata = seed;
            exp   = seed;
        end
        @(negedge clk);
        csr.addr = c_addr[i];
        if (c_kind[i] == "wr") begin
            csr.we    = 1'b1;
            csr.wdata = wdata;
            @(negedge clk);
            csr.we = 1'b0;
            set_check(i, exp, 2'd0);
        end else if (c_kind[i] == "irq") begin
            mei   = c_lines[i];
            pc    = ~c_pc[i];           // only the entry edge sees the case pc
            instr = ~c_instr[i];
            repeat (2) @(posedge clk);  // two sync stages
            @(negedge clk);
            pc    = c_pc[i];
            instr = c_instr[i];
            @(posedge clk);             // trap entry
            @(negedge clk);
            set_check(i, exp, 2'd0);
        end else if (c_kind[i] == "cyc") begin
            set_check(i, '0, 2'd1);
            @(negedge clk);
            chk = 1'b0;
            repeat (c_data[i] - 1) @(negedge clk);
            set_check(i, exp, 2'd2);
        end else begin
            set_check(i, exp, 2'd0);
        end
        @(negedge clk);
        chk = 1'b0;
    endtask

    initial begin
        wait (n_cases > 0);
        #((n_cases * 20 + 100) * 10);
        $display("timeout, the tests did not finish in time");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        csr        = '0;
        pc         = '0;
        instr      = '0;
        mei        = '0;
        chk        = 1'b0;
        mode       = 2'd0;
        name       = '0;
        exp_rdata  = '0;
        exp_irq    = 1'b0;
        exp_trap   = 1'b0;
        exp_target = '0;
        exp_epc    = '0;
        seed       = 32'hdab1;
        load_cases();
        if (n_cases == 0) begin
            $display("no test cases could be read from bench/csr_cases.txt");
            $display(">>> FAIL");
            $finish;
        end else begin
            repeat (8) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            for (int i = 0; i < n_cases; i++) begin
                run_case(i);
            end
            repeat (2) @(negedge clk);
            $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
            if (fail_cnt == 0)
                $display(">>> PASS");
            else
                $display(">>> FAIL");
            $finish;
        end
    end

endmodule

// ==== bench/csr_checker.sv ====
module csr_checker
    import trap_pkg::*;
(
    input  logic         i_CLK,
    input  logic         i_rst_n,
    input  logic [31:0]  i_rdata,
    input  logic         i_irq,
    input  trap_req_t    i_trap,
    input  logic         i_chk,
    input  logic [1:0]   i_mode,        // 0 plain, 1 snapshot, 2 delta from snapshot
    input  logic [127:0] i_name,
    input  logic [31:0]  i_exp_rdata,
    input  logic         i_exp_irq,
    input  logic         i_exp_trap,
    input  logic [31:0]  i_exp_target,
    input  logic [31:0]  i_exp_epc,
    output int           o_pass_cnt,
    output int           o_fail_cnt
);

    logic [31:0] snap;

    initial begin
        o_pass_cnt = 0;
        o_fail_cnt = 0;
        snap       = '0;
    end

    task automatic judge;
        logic [31:0] got;
        logic        ok;
        ok  = 1'b0;
        got = (i_mode == 2'd2) ? i_rdata - snap : i_rdata;
        if (got !== i_exp_rdata)
            $display("Fail %0s rdata expected %h actual %h", i_name, i_exp_rdata, got);
        else if (i_irq !== i_exp_irq)
            $display("Fail %0s irq expected %b actual %b", i_name, i_exp_irq, i_irq);
        else if (i_exp_trap && !i_trap.valid)
            $display("trap pulse missing in test %0s", i_name);
        else if (!i_exp_trap && i_trap.valid)
            $display("trap pulse that should not be there in test %0s", i_name);
        else if (i_exp_trap && i_trap.target !== i_exp_target)
            $display("Fail %0s target expected %h actual %h", i_name, i_exp_target,
                     i_trap.target);
        else if (i_exp_trap && i_trap.epc !== i_exp_epc)
            $display("Fail %0s epc expected %h actual %h", i_name, i_exp_epc, i_trap.epc);
        else
            ok = 1'b1;
        if (ok) begin
            $display("ok   %0s", i_name);
            o_pass_cnt = o_pass_cnt + 1;
        end else begin
            o_fail_cnt = o_fail_cnt + 1;
        end
    endtask

    // values seen here are the ones settled before the edge
    always @(posedge i_CLK) begin
        if (i_rst_n) begin
            if (i_chk && i_mode != 2'd1) begin
                judge();
            end else begin
                if (i_chk) begin
                    snap = i_rdata;
                end
                if (i_trap.valid) begin
                    $display("trap pulse came in a wrong cycle, near test %0s", i_name);
                    o_fail_cnt = o_fail_cnt + 1;
                end
            end
        end
    end

endmodule

// ==== logic/csr_subsys_top.sv ====
module csr_subsys_top
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  logic                 i_CLK,
    input  logic                 i_rst_n,
    input  csr_req_t             i_csr,
    input  logic [31:0]          i_pc,
    input  logic [31:0]          i_instr,
    input  logic [IRQ_LINES-1:0] i_mei,
    output logic [31:0]          o_csr_rdata,
    output logic                 o_irq,
    output trap_req_t            o_trap
);

    logic [IRQ_LINES-1:0] mei_sync;
    logic [63:0]          cycles;
    logic [IRQ_LINES-1:0] irq_vec;
    mcause_t              mcause;
    mtvec_t               mtvec;
    logic                 take;

    event_source u_event_source (
        .i_CLK      (i_CLK),
        .i_rst_n    (i_rst_n),
        .i_mei      (i_mei),
        .o_mei_sync (mei_sync),
        .o_cycles   (cycles)
    );

    csr_file u_csr_file (
        .i_CLK      (i_CLK),
        .i_rst_n    (i_rst_n),
        .i_csr      (i_csr),
        .i_mei_sync (mei_sync),
        .i_cycles   (cycles),
        .i_take     (take),
        .i_pc       (i_pc),
        .i_instr    (i_instr),
        .o_rdata    (o_csr_rdata),
        .o_irq_vec  (irq_vec),
        .o_mcause   (mcause),
        .o_mtvec    (mtvec)
    );

    trap_ctrl u_trap_ctrl (
        .i_CLK      (i_CLK),
        .i_rst_n    (i_rst_n),
        .i_irq_vec  (irq_vec),
        .i_mcause   (mcause),
        .i_mtvec    (mtvec),
        .i_pc       (i_pc),
        .o_take     (take),
        .o_trap     (o_trap)
    );

    assign o_irq = |irq_vec;    // any enabled line pending

endmodule

// ==== logic/trap_ctrl.sv ====
module trap_ctrl
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  logic                 i_CLK,
    input  logic                 i_rst_n,
    input  logic [IRQ_LINES-1:0] i_irq_vec,
    input  mcause_t              i_mcause,
    input  mtvec_t               i_mtvec,
    input  logic [31:0]          i_pc,
    output logic                 o_take,
    output trap_req_t            o_trap
);

    logic [31:0] base_addr;
    logic [31:0] target;

    function automatic logic [IRQ_IDX_W-1:0] lowest_idx(input logic [IRQ_LINES-1:0] vec);
        logic [IRQ_IDX_W-1:0] idx;
        idx = '0;
        for (int i = IRQ_LINES - 1; i >= 0; i--) begin
            if (vec[i]) idx = IRQ_IDX_W'(i);
        end
        return idx;
    endfunction

    // no new entry while the previous cause is still flagged
    assign o_take = (|i_irq_vec) && !i_mcause.irq;

    assign base_addr = {i_mtvec.base, 2'b00};

    always_comb begin
        case (i_mtvec.mode)
            MODE_DIRECT:   target = base_addr;
            MODE_VECTORED: target = base_addr + (32'(lowest_idx(i_irq_vec)) << 2);
            default:       target = base_addr;
        endcase
    end

    always_ff @(posedge i_CLK or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_trap <= '0;
        end else begin
            o_trap.valid  <= o_take;
            o_trap.target <= target;
            o_trap.epc    <= i_pc;
        end
    end

    a_single_pulse: assert property (
        @(posedge i_CLK) disable iff (!i_rst_n)
        o_trap.valid |=> !o_trap.valid
    );

endmodule

// ==== logic/csr_file.sv ====
module csr_file
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  logic                 i_CLK,
    input  logic                 i_rst_n,
    input  csr_req_t             i_csr,
    input  logic [IRQ_LINES-1:0] i_mei_sync,
    input  logic [63:0]          i_cycles,
    input  logic                 i_take,
    input  logic [31:0]          i_pc,
    input  logic [31:0]          i_instr,
    output logic [31:0]          o_rdata,
    output logic [IRQ_LINES-1:0] o_irq_vec,
    output mcause_t              o_mcause,
    output mtvec_t               o_mtvec
);

    logic [31:0] mie;
    mtvec_t      mtvec;
    logic [31:0] mscratch;
    logic [31:0] mepc;
    mcause_t     mcause;
    logic [31:0] mtval;
    logic [31:0] mcycle;
    logic [31:0] mcycleh;

    // software writable registers
    always_ff @(posedge i_CLK or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mie      <= MIE_RESET;
            mtvec    <= '0;
            mscratch <= '0;
        end else if (i_csr.we) begin
            case (i_csr.addr)
                CSR_MIE:      mie      <= i_csr.wdata;
                CSR_MTVEC:    mtvec    <= i_csr.wdata;
                CSR_MSCRATCH: mscratch <= i_csr.wdata;
                default: ;                       // read only or unknown
            endcase
        end
    end

    assign o_irq_vec = i_mei_sync & mie[IRQ_LINES-1:0];

    // hardware updated registers
    always_ff @(posedge i_CLK or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mcause  <= '0;
            mepc    <= '0;
            mtval   <= '0;
            mcycle  <= '0;
            mcycleh <= '0;
        end else begin
            mcause.irq  <= |o_irq_vec;          // follows the lines every cycle
            mcause.zero <= '0;
            mcause.vec  <= o_irq_vec;
            {mcycleh, mcycle} <= i_cycles;      // one cycle behind the counter
            if (i_take) begin
                mepc  <= i_pc;
                mtval <= i_instr;
            end
        end
    end

    always_comb begin
        case (i_csr.addr)
            CSR_MIE:      o_rdata = mie;
            CSR_MTVEC:    o_rdata = mtvec;
            CSR_MSCRATCH: o_rdata = mscratch;
            CSR_MEPC:     o_rdata = mepc;
            CSR_MCAUSE:   o_rdata = mcause;
            CSR_MTVAL:    o_rdata = mtval;
            CSR_MCYCLE:   o_rdata = mcycle;
            CSR_MCYCLEH:  o_rdata = mcycleh;
            default:      o_rdata = '0;
        endcase
    end

    assign o_mcause = mcause;
    assign o_mtvec  = mtvec;

    // mepc only moves on a take from the trap controller
    a_mepc_on_take: assert property (
        @(posedge i_CLK) disable iff (!i_rst_n)
        !$stable(mepc) |-> $past(i_take)
    );

endmodule

// ==== logic/event_source.sv ====
module event_source
    import trap_pkg::*;
(
    input  logic                 i_CLK,
    input  logic                 i_rst_n,
    input  logic [IRQ_LINES-1:0] i_mei,
    output logic [IRQ_LINES-1:0] o_mei_sync,
    output logic [63:0]          o_cycles
);

    logic [IRQ_LINES-1:0] mei_meta;

    // two flops per line, the lines come in unclocked
    always_ff @(posedge i_CLK or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mei_meta   <= '0;
            o_mei_sync <= '0;
        end else begin
            mei_meta   <= i_mei;
            o_mei_sync <= mei_meta;
        end
    end

    always_ff @(posedge i_CLK or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_cycles <= '0;
        end else begin
            o_cycles <= o_cycles + 64'd1;   // free running
        end
    end

    // counter steps by one on every edge after reset is released
    a_cycle_step: assert property (
        @(posedge i_CLK) disable iff (!i_rst_n)
        $past(i_rst_n) |-> o_cycles == $past(o_cycles) + 64'd1
    );

endmodule

// ==== logic/trap_pkg.sv ====
package trap_pkg;

    localparam int IRQ_LINES = 6;
    localparam int IRQ_IDX_W = $clog2(IRQ_LINES);

    localparam logic [1:0] MODE_DIRECT   = 2'd0;
    localparam logic [1:0] MODE_VECTORED = 2'd1;   // other codes fall back to direct

    typedef struct packed {
        logic [29:0] base;     // word address of handler
        logic [1:0]  mode;
    } mtvec_t;

    // request to fetch, valid for one cycle
    typedef struct packed {
        logic        valid;
        logic [31:0] target;
        logic [31:0] epc;
    } trap_req_t;

endpackage

// ==== logic/csr_pkg.sv ====
package csr_pkg;

    localparam int CSR_ADDR_W = 12;

    // machine trap setup
    localparam logic [CSR_ADDR_W-1:0] CSR_MIE      = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC    = 12'h305;

    // machine trap handling
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE   = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVAL    = 12'h343;

    // counters
    localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLE   = 12'hB00;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLEH  = 12'hB80;

    localparam logic [31:0] MIE_RESET = 32'd1;     // line 0 enabled

    // one csr access, write strobe plus address and data
    typedef struct packed {
        logic                  we;
        logic [CSR_ADDR_W-1:0] addr;
        logic [31:0]           wdata;
    } csr_req_t;

    // mcause as seen by software
    typedef struct packed {
        logic        irq;      // interrupt flag, msb
        logic [24:0] zero;
        logic [5:0]  vec;      // masked pending lines
    } mcause_t;

endpackage
